//--- files.f
+incdir+rtl
rtl/axi_bus_pkg.sv
rtl/axi_read_arbiter.sv
rtl/axi_sram_slave.sv
rtl/axi_mem_top.sv
verif/axi_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module axi_mem_tb --Mdir obj_dir -o axi_mem_sim

out=$(./obj_dir/axi_mem_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
   exit 0
else
   exit 1
fi

//--- verif/axi_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bus_config.svh"

module axi_mem_tb import axi_bus_pkg::*; ();

   typedef enum {OP_WR, OP_RD, OP_BOTH} op_e;   // OP_BOTH is a read on both masters at once.

   logic                   clk, rst;
   logic [`AXI_ADDR_W-1:0] araddr_ifu, araddr_mem, awaddr_mem;
   logic [`AXI_LEN_W-1:0]  arlen_ifu, arlen_mem, awlen_mem;
   logic [1:0]             arburst_ifu, arburst_mem, awburst_mem;
   logic                   arvalid_ifu, arvalid_mem, rready_ifu, rready_mem;
   logic                   arready_ifu, arready_mem, rlast_ifu, rlast_mem;
   logic                   rvalid_ifu, rvalid_mem;
   logic [`AXI_DATA_W-1:0] rdata_ifu, rdata_mem, wdata_mem;
   logic [1:0]             rresp_ifu, rresp_mem, bresp_mem;
   logic [`AXI_STRB_W-1:0] wstrb_mem;
   logic                   awvalid_mem, awready_mem, wlast_mem, wvalid_mem, wready_mem;
   logic                   bvalid_mem, bready_mem;

   // Stimulus table, one entry per row in each queue.
   string                  row_name [$];
   op_e                    row_op [$];
   arb_owner_e             row_mst [$];
   logic [`AXI_ADDR_W-1:0] row_addr [$];
   logic [`AXI_ADDR_W-1:0] row_addr2 [$];  // Mem address of a dual read.
   int                     row_len [$];
   axi_burst_e             row_burst [$];
   logic [`AXI_STRB_W-1:0] row_strb [$];
   axi_resp_e              row_resp [$];

   logic [`AXI_DATA_W-1:0] model [`SRAM_WORDS];  // Expected SRAM contents.
   logic [31:0]            lfsr = 32'hcb84c460;
   int                     cycles = 0;
   int                     limit = 0;
   int                     last_ifu_cyc, first_mem_cyc;

   axi_mem_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Run limit, set once the table is known.
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Errors found");
         $fatal(1, "Timeout after %0d cycles, a handshake never completed.", cycles);
      end
   end

   task automatic add_row(input string name, input op_e op, input arb_owner_e mst,
                          input logic [31:0] addr, input logic [31:0] addr2, input int len,
                          input axi_burst_e burst, input logic [7:0] strb,
                          input axi_resp_e resp);
      row_name.push_back(name);
      row_op.push_back(op);
      row_mst.push_back(mst);
      row_addr.push_back(addr);
      row_addr2.push_back(addr2);
      row_len.push_back(len);
      row_burst.push_back(burst);
      row_strb.push_back(strb);
      row_resp.push_back(resp);
   endtask

   task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", what, exp, act);
         $display("Errors found");
         $fatal(1, "** Error in %s", what);
      end
   endtask

   // Galois LFSR, one bit per step.
   function automatic logic lfsr_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h80200003;
      return b;
   endfunction

   function automatic logic [63:0] rand_word();
      logic [63:0] w;
      int          i;
      w = '0;
      for (i = 0; i < 64; i++) w = {w[62:0], lfsr_bit()};
      return w;
   endfunction

   function automatic logic [31:0] beat_addr(input logic [31:0] base, input axi_burst_e burst,
                                             input int k);
      return (burst == BURST_INCR) ? base + 32'(8 * k) : base;   // FIXED stays put.
   endfunction

   function automatic logic in_range(input logic [31:0] a);
      return a < 32'(`SRAM_WORDS * 8);
   endfunction

   function automatic int word_idx(input logic [31:0] a);
      return int'((a >> 3) % `SRAM_WORDS);
   endfunction

   // One read beat against the model.
   task automatic check_beat(input string name, input logic [31:0] a, input int n,
                             input int len, input axi_resp_e exp_resp,
                             input logic [63:0] data, input logic [1:0] resp, input logic last);
      logic [63:0] exp_data;
      exp_data = in_range(a) ? model[word_idx(a)] : '0;   // Zero data outside the SRAM.
      check($sformatf("%s beat %0d data", name, n), exp_data, data);
      check($sformatf("%s beat %0d resp", name, n), 64'(exp_resp), 64'(resp));
      check($sformatf("%s beat %0d rlast", name, n), 64'(n == len), 64'(last));
   endtask

   task automatic read_ifu(input string name, input logic [31:0] addr, input int len,
                           input axi_burst_e burst, input axi_resp_e exp_resp);
      int   n;
      logic ar_fire;
      n = 0;
      @(negedge clk);
      araddr_ifu  = addr;
      arlen_ifu   = `AXI_LEN_W'(len);
      arburst_ifu = burst;
      arvalid_ifu = 1'b1;
      while (n <= len) begin
         ar_fire    = arvalid_ifu && arready_ifu;   // AR moves on the next rising edge.
         rready_ifu = lfsr_bit() | lfsr_bit();      // Stall about one cycle in four.
         if (rvalid_ifu && rready_ifu) begin
            check_beat(name, beat_addr(addr, burst, n), n, len, exp_resp,
                       rdata_ifu, rresp_ifu, rlast_ifu);
            check({name, " rvalid_mem"}, 64'(0), 64'(rvalid_mem));
            last_ifu_cyc = cycles;
            n++;
         end
         @(negedge clk);
         if (ar_fire) arvalid_ifu = 1'b0;
      end
      rready_ifu = 1'b0;
   endtask

   task automatic read_mem(input string name, input logic [31:0] addr, input int len,
                           input axi_burst_e burst, input axi_resp_e exp_resp);
      int   n;
      logic ar_fire;
      n = 0;
      @(negedge clk);
      araddr_mem  = addr;
      arlen_mem   = `AXI_LEN_W'(len);
      arburst_mem = burst;
      arvalid_mem = 1'b1;
      while (n <= len) begin
         ar_fire    = arvalid_mem && arready_mem;
         rready_mem = lfsr_bit() | lfsr_bit();
         if (rvalid_mem && rready_mem) begin
            check_beat(name, beat_addr(addr, burst, n), n, len, exp_resp,
                       rdata_mem, rresp_mem, rlast_mem);
            if (n == 0) first_mem_cyc = cycles;
            n++;
         end
         @(negedge clk);
         if (ar_fire) arvalid_mem = 1'b0;
      end
      rready_mem = 1'b0;
   endtask

   task automatic write_mem(input string name, input logic [31:0] addr, input int len,
                            input axi_burst_e burst, input logic [7:0] strb,
                            input axi_resp_e exp_resp);
      int          n, i;
      logic        aw_fire, w_fire;
      logic [31:0] a;
      n = 0;
      @(negedge clk);
      awaddr_mem  = addr;
      awlen_mem   = `AXI_LEN_W'(len);
      awburst_mem = burst;
      awvalid_mem = 1'b1;
      wdata_mem   = rand_word();
      wstrb_mem   = strb;
      wlast_mem   = (len == 0);
      wvalid_mem  = 1'b1;   // Held until the slave opens the burst.
      while (n <= len) begin
         aw_fire = awvalid_mem && awready_mem;
         w_fire  = wvalid_mem && wready_mem;
         @(negedge clk);
         if (aw_fire) awvalid_mem = 1'b0;
         if (w_fire) begin
            a = beat_addr(addr, burst, n);
            if (in_range(a)) begin
               for (i = 0; i < `AXI_STRB_W; i++) begin
                  if (strb[i]) model[word_idx(a)][8*i +: 8] = wdata_mem[8*i +: 8];
               end
            end
            n++;
            if (n <= len) wdata_mem = rand_word();
            wlast_mem  = (n == len);
            wvalid_mem = (n <= len);
         end
      end
      bready_mem = 1'b1;
      while (!bvalid_mem) @(negedge clk);
      check({name, " bresp"}, 64'(exp_resp), 64'(bresp_mem));
      @(negedge clk);
      bready_mem = 1'b0;
   endtask

   initial begin
      int i;
      int beats;
      add_row("incr_wr",  OP_WR,   OWN_MEM, 32'h100, 32'h0,   7,  BURST_INCR,  8'hff, RESP_OKAY);
      add_row("incr_rd",  OP_RD,   OWN_MEM, 32'h100, 32'h0,   7,  BURST_INCR,  8'h00, RESP_OKAY);
      add_row("ifu_rd",   OP_RD,   OWN_IFU, 32'h100, 32'h0,   7,  BURST_INCR,  8'h00, RESP_OKAY);
      add_row("low_wr",   OP_WR,   OWN_MEM, 32'h000, 32'h0,   3,  BURST_INCR,  8'hff, RESP_OKAY);
      add_row("strb_wr",  OP_WR,   OWN_MEM, 32'h108, 32'h0,   1,  BURST_INCR,  8'h5a, RESP_OKAY);
      add_row("strb_rd",  OP_RD,   OWN_MEM, 32'h100, 32'h0,   3,  BURST_INCR,  8'h00, RESP_OKAY);
      add_row("fixed_wr", OP_WR,   OWN_MEM, 32'h010, 32'h0,   3,  BURST_FIXED, 8'h3c, RESP_OKAY);
      add_row("fixed_rd", OP_RD,   OWN_IFU, 32'h010, 32'h0,   3,  BURST_FIXED, 8'h00, RESP_OKAY);
      add_row("long_wr",  OP_WR,   OWN_MEM, 32'h200, 32'h0,   15, BURST_INCR,  8'hff, RESP_OKAY);
      add_row("dual_rd",  OP_BOTH, OWN_IFU, 32'h100, 32'h200, 7,  BURST_INCR,  8'h00, RESP_OKAY);
      add_row("long_rd",  OP_RD,   OWN_MEM, 32'h200, 32'h0,   15, BURST_INCR,  8'h00, RESP_OKAY);
      add_row("edge_wr",  OP_WR,   OWN_MEM, 32'h7f0, 32'h0,   3,  BURST_INCR,  8'hff, RESP_SLVERR);
      add_row("edge_rd",  OP_RD,   OWN_IFU, 32'h7f0, 32'h0,   1,  BURST_INCR,  8'h00, RESP_OKAY);
      add_row("oor_wr",   OP_WR,   OWN_MEM, 32'h800, 32'h0,   1,  BURST_INCR,  8'hff, RESP_SLVERR);
      add_row("oor_rd",   OP_RD,   OWN_MEM, 32'h808, 32'h0,   2,  BURST_INCR,  8'h00, RESP_SLVERR);
      add_row("alias_rd", OP_RD,   OWN_IFU, 32'h000, 32'h0,   3,  BURST_INCR,  8'h00, RESP_OKAY);

      beats = 0;
      for (i = 0; i < row_name.size(); i++) begin
         beats += (row_op[i] == OP_BOTH) ? 2 * (row_len[i] + 1) : row_len[i] + 1;
      end
      limit = 20 * beats + 100;

      rst         = 1'b1;
      araddr_ifu  = '0;
      arlen_ifu   = '0;
      arburst_ifu = 2'b00;
      arvalid_ifu = 1'b0;
      rready_ifu  = 1'b0;
      araddr_mem  = '0;
      arlen_mem   = '0;
      arburst_mem = 2'b00;
      arvalid_mem = 1'b0;
      rready_mem  = 1'b0;
      awaddr_mem  = '0;
      awlen_mem   = '0;
      awburst_mem = 2'b00;
      awvalid_mem = 1'b0;
      wdata_mem   = '0;
      wstrb_mem   = '0;
      wlast_mem   = 1'b0;
      wvalid_mem  = 1'b0;
      bready_mem  = 1'b0;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      for (i = 0; i < row_name.size(); i++) begin
         case (row_op[i])
            OP_WR: write_mem(row_name[i], row_addr[i], row_len[i], row_burst[i],
                             row_strb[i], row_resp[i]);
            OP_RD: begin
               if (row_mst[i] == OWN_IFU)
                  read_ifu(row_name[i], row_addr[i], row_len[i], row_burst[i], row_resp[i]);
               else
                  read_mem(row_name[i], row_addr[i], row_len[i], row_burst[i], row_resp[i]);
            end
            default: begin
               // Same falling edge on both masters, ifu must finish first.
               fork
                  read_ifu({row_name[i], " ifu"}, row_addr[i], row_len[i], row_burst[i],
                           row_resp[i]);
                  read_mem({row_name[i], " mem"}, row_addr2[i], row_len[i], row_burst[i],
                           row_resp[i]);
               join
               check({row_name[i], " ifu before mem"}, 64'(1),
                     64'(last_ifu_cyc < first_mem_cyc));
            end
         endcase
      end

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/axi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bus_config.svh"

module axi_mem_top (
   input  logic                   clk,
   input  logic                   rst,

   // Fetch unit reads.
   input  logic [`AXI_ADDR_W-1:0] araddr_ifu,
   input  logic [`AXI_LEN_W-1:0]  arlen_ifu,
   input  logic [1:0]             arburst_ifu,
   input  logic                   arvalid_ifu,
   output logic                   arready_ifu,
   output logic [`AXI_DATA_W-1:0] rdata_ifu,
   output logic [1:0]             rresp_ifu,
   output logic                   rlast_ifu,
   output logic                   rvalid_ifu,
   input  logic                   rready_ifu,

   // Load/store unit reads.
   input  logic [`AXI_ADDR_W-1:0] araddr_mem,
   input  logic [`AXI_LEN_W-1:0]  arlen_mem,
   input  logic [1:0]             arburst_mem,
   input  logic                   arvalid_mem,
   output logic                   arready_mem,
   output logic [`AXI_DATA_W-1:0] rdata_mem,
   output logic [1:0]             rresp_mem,
   output logic                   rlast_mem,
   output logic                   rvalid_mem,
   input  logic                   rready_mem,

   // Load/store unit writes.
   input  logic [`AXI_ADDR_W-1:0] awaddr_mem,
   input  logic [`AXI_LEN_W-1:0]  awlen_mem,
   input  logic [1:0]             awburst_mem,
   input  logic                   awvalid_mem,
   output logic                   awready_mem,
   input  logic [`AXI_DATA_W-1:0] wdata_mem,
   input  logic [`AXI_STRB_W-1:0] wstrb_mem,
   input  logic                   wlast_mem,
   input  logic                   wvalid_mem,
   output logic                   wready_mem,
   output logic [1:0]             bresp_mem,
   output logic                   bvalid_mem,
   input  logic                   bready_mem
);

   // Arbiter to slave.
   logic [`AXI_ADDR_W-1:0] araddr, awaddr;
   logic [`AXI_LEN_W-1:0]  arlen, awlen;
   logic [1:0]             arburst, awburst;
   logic                   arvalid, arready;
   logic [`AXI_DATA_W-1:0] rdata, wdata;
   logic [1:0]             rresp, bresp;
   logic                   rlast, rvalid, rready;
   logic                   awvalid, awready;
   logic [`AXI_STRB_W-1:0] wstrb;
   logic                   wlast, wvalid, wready;
   logic                   bvalid, bready;

   axi_read_arbiter u_arb (
      .clk, .rst,
      .araddr_ifu, .arlen_ifu, .arburst_ifu, .arvalid_ifu, .arready_ifu,
      .rdata_ifu, .rresp_ifu, .rlast_ifu, .rvalid_ifu, .rready_ifu,
      .araddr_mem, .arlen_mem, .arburst_mem, .arvalid_mem, .arready_mem,
      .rdata_mem, .rresp_mem, .rlast_mem, .rvalid_mem, .rready_mem,
      .awaddr_mem, .awlen_mem, .awburst_mem, .awvalid_mem, .awready_mem,
      .wdata_mem, .wstrb_mem, .wlast_mem, .wvalid_mem, .wready_mem,
      .bresp_mem, .bvalid_mem, .bready_mem,
      .araddr, .arlen, .arburst, .arvalid, .arready,
      .rdata, .rresp, .rlast, .rvalid, .rready,
      .awaddr, .awlen, .awburst, .awvalid, .awready,
      .wdata, .wstrb, .wlast, .wvalid, .wready,
      .bresp, .bvalid, .bready
   );

   axi_sram_slave u_sram (
      .clk, .rst,
      .araddr, .arlen, .arburst, .arvalid, .arready,
      .rdata, .rresp, .rlast, .rvalid, .rready,
      .awaddr, .awlen, .awburst, .awvalid, .awready,
      .wdata, .wstrb, .wlast, .wvalid, .wready,
      .bresp, .bvalid, .bready
   );

endmodule

`default_nettype wire

//--- rtl/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bus_config.svh"

module axi_sram_slave import axi_bus_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,

   // Read address and data.
   input  logic [`AXI_ADDR_W-1:0] araddr,
   input  logic [`AXI_LEN_W-1:0]  arlen,
   input  logic [1:0]             arburst,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [`AXI_DATA_W-1:0] rdata,
   output logic [1:0]             rresp,
   output logic                   rlast,
   output logic                   rvalid,
   input  logic                   rready,

   // Write address, data and response.
   input  logic [`AXI_ADDR_W-1:0] awaddr,
   input  logic [`AXI_LEN_W-1:0]  awlen,
   input  logic [1:0]             awburst,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`AXI_DATA_W-1:0] wdata,
   input  logic [`AXI_STRB_W-1:0] wstrb,
   input  logic                   wlast,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready
);

   localparam int IDX_W  = $clog2(`SRAM_WORDS);
   localparam int LEFT_W = $clog2(`AXI_MAX_LEN + 1);
   localparam logic [`AXI_ADDR_W-1:0] SRAM_BYTES = `AXI_ADDR_W'(`SRAM_WORDS * 8);
   localparam logic [`AXI_ADDR_W-1:0] BEAT_BYTES = `AXI_ADDR_W'(8);

   logic [`AXI_DATA_W-1:0] mem [`SRAM_WORDS]; // No reset on the array.

   // Read engine state.
   logic                   rd_busy;
   logic [`AXI_ADDR_W-1:0] rd_addr;
   logic [LEFT_W-1:0]      rd_left;     // Beats after the current one.
   axi_burst_e             rd_burst;
   logic                   rd_oor;
   logic [IDX_W-1:0]       rd_idx;
   logic                   r_fire;

   // Write engine state.
   logic                   wr_open;
   logic [`AXI_ADDR_W-1:0] wr_addr;
   logic [LEFT_W-1:0]      wr_left;
   axi_burst_e             wr_burst;
   logic                   wr_err;      // Sticky, some beat was out of range.
   logic                   wr_oor;
   logic [IDX_W-1:0]       wr_idx;
   logic                   w_fire;
   logic                   w_end;

   assign rd_oor = (rd_addr >= SRAM_BYTES);
   assign rd_idx = rd_addr[IDX_W+2:3];
   assign r_fire = rvalid && rready;

   assign arready = !rd_busy;
   assign rvalid  = rd_busy;
   assign rlast   = rd_busy && (rd_left == '0);
   assign rdata   = rd_oor ? '0 : mem[rd_idx];   // Async read, beat held while stalled.
   assign rresp   = rd_oor ? RESP_SLVERR : RESP_OKAY;

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_busy <= 1'b0;
      end else if (arvalid && arready) begin
         rd_busy <= 1'b1;
      end else if (r_fire && rlast) begin
         rd_busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         rd_addr  <= araddr;
         rd_left  <= arlen[LEFT_W-1:0];  // Clipped to 16 beats.
         rd_burst <= axi_burst_e'(arburst);
      end else if (r_fire) begin
         rd_left <= rd_left - 1'b1;
         if (rd_burst == BURST_INCR) rd_addr <= rd_addr + BEAT_BYTES;
      end
   end

   assign wr_oor  = (wr_addr >= SRAM_BYTES);
   assign wr_idx  = wr_addr[IDX_W+2:3];
   assign w_fire  = wvalid && wready;
   assign w_end   = wlast || (wr_left == '0); // Length also closes a burst.

   assign awready = !wr_open && !bvalid; // One write in flight, response included.
   assign wready  = wr_open;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_open <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         if (awvalid && awready) wr_open <= 1'b1;
         else if (w_fire && w_end) wr_open <= 1'b0;
         if (w_fire && w_end) bvalid <= 1'b1;
         else if (bvalid && bready) bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         wr_addr  <= awaddr;
         wr_left  <= awlen[LEFT_W-1:0];
         wr_burst <= axi_burst_e'(awburst);
         wr_err   <= 1'b0;
      end else if (w_fire) begin
         wr_left <= wr_left - 1'b1;
         wr_err  <= wr_err || wr_oor;
         if (wr_burst == BURST_INCR) wr_addr <= wr_addr + BEAT_BYTES;
         if (w_end) bresp <= (wr_err || wr_oor) ? RESP_SLVERR : RESP_OKAY;
      end
   end

   // Byte merge under wstrb, out of range beats dropped.
   always_ff @(posedge clk) begin
      if (w_fire && !wr_oor) begin
         for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (wstrb[i]) mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
   end

   // A stalled beat keeps its data, response and last flag.
   a_r_stall_stable: assert property (@(posedge clk) disable iff (rst)
      (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast)));

endmodule

`default_nettype wire

//--- rtl/axi_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bus_config.svh"

module axi_read_arbiter import axi_bus_pkg::*; (
   input  logic                   clk,
   input  logic                   rst,

   // Fetch unit read group.
   input  logic [`AXI_ADDR_W-1:0] araddr_ifu,
   input  logic [`AXI_LEN_W-1:0]  arlen_ifu,
   input  logic [1:0]             arburst_ifu,
   input  logic                   arvalid_ifu,
   output logic                   arready_ifu,
   output logic [`AXI_DATA_W-1:0] rdata_ifu,
   output logic [1:0]             rresp_ifu,
   output logic                   rlast_ifu,
   output logic                   rvalid_ifu,
   input  logic                   rready_ifu,

   // Load/store unit read group.
   input  logic [`AXI_ADDR_W-1:0] araddr_mem,
   input  logic [`AXI_LEN_W-1:0]  arlen_mem,
   input  logic [1:0]             arburst_mem,
   input  logic                   arvalid_mem,
   output logic                   arready_mem,
   output logic [`AXI_DATA_W-1:0] rdata_mem,
   output logic [1:0]             rresp_mem,
   output logic                   rlast_mem,
   output logic                   rvalid_mem,
   input  logic                   rready_mem,

   // Load/store unit write group.
   input  logic [`AXI_ADDR_W-1:0] awaddr_mem,
   input  logic [`AXI_LEN_W-1:0]  awlen_mem,
   input  logic [1:0]             awburst_mem,
   input  logic                   awvalid_mem,
   output logic                   awready_mem,
   input  logic [`AXI_DATA_W-1:0] wdata_mem,
   input  logic [`AXI_STRB_W-1:0] wstrb_mem,
   input  logic                   wlast_mem,
   input  logic                   wvalid_mem,
   output logic                   wready_mem,
   output logic [1:0]             bresp_mem,
   output logic                   bvalid_mem,
   input  logic                   bready_mem,

   // Slave side read.
   output logic [`AXI_ADDR_W-1:0] araddr,
   output logic [`AXI_LEN_W-1:0]  arlen,
   output logic [1:0]             arburst,
   output logic                   arvalid,
   input  logic                   arready,
   input  logic [`AXI_DATA_W-1:0] rdata,
   input  logic [1:0]             rresp,
   input  logic                   rlast,
   input  logic                   rvalid,
   output logic                   rready,

   // Slave side write.
   output logic [`AXI_ADDR_W-1:0] awaddr,
   output logic [`AXI_LEN_W-1:0]  awlen,
   output logic [1:0]             awburst,
   output logic                   awvalid,
   input  logic                   awready,
   output logic [`AXI_DATA_W-1:0] wdata,
   output logic [`AXI_STRB_W-1:0] wstrb,
   output logic                   wlast,
   output logic                   wvalid,
   input  logic                   wready,
   input  logic [1:0]             bresp,
   input  logic                   bvalid,
   output logic                   bready
);

   arb_owner_e owner, owner_nxt;
   logic       ar_done;      // AR accepted, data phase running.
   logic       sel_ifu, sel_mem;
   logic       last_beat;

   assign sel_ifu   = (owner == OWN_IFU);
   assign sel_mem   = (owner == OWN_MEM);
   assign last_beat = rvalid && rready && rlast;

   // Fixed priority, ifu first.
   always_comb begin
      owner_nxt = owner;
      case (owner)
         OWN_NONE: begin
            if (arvalid_ifu) owner_nxt = OWN_IFU;
            else if (arvalid_mem) owner_nxt = OWN_MEM;
         end
         OWN_IFU, OWN_MEM: begin
            if (last_beat) owner_nxt = OWN_NONE; // Release after the last beat.
         end
         default: owner_nxt = OWN_NONE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         owner   <= OWN_NONE;
         ar_done <= 1'b0;
      end else begin
         owner <= owner_nxt;
         if (last_beat) ar_done <= 1'b0;
         else if (arvalid && arready) ar_done <= 1'b1;
      end
   end

   // Address phase from the owner only.
   assign arvalid = ((sel_ifu && arvalid_ifu) || (sel_mem && arvalid_mem)) && !ar_done;
   assign araddr  = sel_ifu ? araddr_ifu  : (sel_mem ? araddr_mem  : '0);
   assign arlen   = sel_ifu ? arlen_ifu   : (sel_mem ? arlen_mem   : '0);
   assign arburst = sel_ifu ? arburst_ifu : (sel_mem ? arburst_mem : 2'b00);
   assign rready  = sel_ifu ? rready_ifu  : (sel_mem ? rready_mem  : 1'b0);

   assign arready_ifu = sel_ifu && !ar_done && arready;
   assign arready_mem = sel_mem && !ar_done && arready;

   // Data back to the owner, zeros to the other one.
   assign rdata_ifu  = sel_ifu ? rdata  : '0;
   assign rresp_ifu  = sel_ifu ? rresp  : 2'b00;
   assign rlast_ifu  = sel_ifu && rlast;
   assign rvalid_ifu = sel_ifu && rvalid;
   assign rdata_mem  = sel_mem ? rdata  : '0;
   assign rresp_mem  = sel_mem ? rresp  : 2'b00;
   assign rlast_mem  = sel_mem && rlast;
   assign rvalid_mem = sel_mem && rvalid;

   // Writes belong to mem alone.
   assign awaddr      = awaddr_mem;
   assign awlen       = awlen_mem;
   assign awburst     = awburst_mem;
   assign awvalid     = awvalid_mem;
   assign awready_mem = awready;
   assign wdata       = wdata_mem;
   assign wstrb       = wstrb_mem;
   assign wlast       = wlast_mem;
   assign wvalid      = wvalid_mem;
   assign wready_mem  = wready;
   assign bresp_mem   = bresp;
   assign bvalid_mem  = bvalid;
   assign bready      = bready_mem;

   // Slave data only inside a granted, open burst.
   a_rvalid_granted: assert property (@(posedge clk) disable iff (rst)
      rvalid |-> (ar_done && owner != OWN_NONE));

endmodule

`default_nettype wire

//--- rtl/axi_bus_pkg.sv
`default_nettype none

package axi_bus_pkg;

   // Response codes.
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   // Burst types, WRAP is not supported.
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01
   } axi_burst_e;

   // Read grant owner.
   typedef enum logic [1:0] {
      OWN_NONE = 2'b00,
      OWN_IFU  = 2'b01,
      OWN_MEM  = 2'b10
   } arb_owner_e;

endpackage

`default_nettype wire

//--- rtl/axi_bus_config.svh
`ifndef AXI_BUS_CONFIG_SVH
`define AXI_BUS_CONFIG_SVH

// Bus widths.
`define AXI_ADDR_W  32
`define AXI_DATA_W  64   // One SRAM word per beat.
`define AXI_STRB_W  8
`define AXI_LEN_W   8    // Burst length field.

`define SRAM_WORDS  256  // Word index is addr[10:3].
`define AXI_MAX_LEN 15   // 16 beats at most.

`endif
